/* testbench/nabp_stimulus.txt */
// one record per word: top digit 1 is an angle job and its base,
// top digit 2 is a filtered sample; the low four digits hold the value
10000
11000
10600
1f800
12800
// sample stream, continuous across all angles
25a00 25a01 25a02 25a03
25a04 25a05 25a06 25a07
25a08 25a09 25a0a 25a0b
25a0c 25a0d 25a0e 25a0f
25a10 25a11 25a12 25a13
25a14 25a15 25a16 25a17
25a18 25a19 25a1a 25a1b
25a1c 25a1d 25a1e 25a1f
25a20 25a21 25a22 25a23
25a24 25a25 25a26 25a27
25a28 25a29 25a2a

/* tb.f */
verilog/nabp_pkg.sv
verilog/nabp_sequencer.sv
verilog/nabp_shifter.sv
verilog/nabp_filter_mapper.sv
verilog/nabp_top.sv
testbench/nabp_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module nabp_tb

status=0
./obj_dir/Vnabp_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log || [ "$status" -ne 0 ]; then
    exit 1
fi
exit 0

/* testbench/nabp_tb.sv */
`timescale 1ns/1ps

module nabp_tb;

    localparam int DATA_W      = nabp_pkg::DEF_DATA_WIDTH;
    localparam int ACCU_W      = nabp_pkg::DEF_ACCU_WIDTH;
    localparam int ACCU_FRAC   = nabp_pkg::DEF_ACCU_FRAC;
    localparam int FILL_DEPTH  = nabp_pkg::DEF_FILL_DEPTH;
    localparam int IMAGE_SIZE  = nabp_pkg::DEF_IMAGE_SIZE;
    localparam int IN_DEPTH    = nabp_pkg::DEF_IN_DEPTH;
    localparam int OUT_CREDITS = nabp_pkg::DEF_OUT_CREDITS;
    localparam int JOB_CREDITS = nabp_pkg::DEF_JOB_CREDITS;
    localparam int STIM_WORDS  = 64;
    localparam int WAIT_LIMIT  = 2000;
    localparam int RUN_LIMIT   = 20000;

    logic              clk;
    logic              reset_n;
    logic              job_valid;
    logic [ACCU_W-1:0] job_base;
    logic              job_credit;
    logic              sample_valid;
    logic [DATA_W-1:0] sample_data;
    logic              sample_credit;
    logic              line_valid;
    logic [DATA_W-1:0] line_data;
    logic              out_credit;

    logic [19:0]       stim_mem [STIM_WORDS];
    logic [ACCU_W-1:0] job_q    [$];
    logic [DATA_W-1:0] sample_q [$];
    logic [DATA_W-1:0] exp_q    [$];
    logic [DATA_W-1:0] exp_val;

    int samples_needed   = 0;
    int exp_total        = 0;
    int jobs_sent        = 0;
    int jobs_returned    = 0;
    int samples_sent     = 0;
    int samples_returned = 0;
    int lines_seen       = 0;
    int lines_in_angle   = 0;
    int credits_returned = 0;
    int mismatch_count   = 0;
    int other_errors     = 0;
    bit stop_run         = 1'b0;

    nabp_top #(
        .DATA_WIDTH  (DATA_W),
        .ACCU_WIDTH  (ACCU_W),
        .ACCU_FRAC   (ACCU_FRAC),
        .FILL_DEPTH  (FILL_DEPTH),
        .IMAGE_SIZE  (IMAGE_SIZE),
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS),
        .JOB_CREDITS (JOB_CREDITS)
    ) DUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .job_valid     (job_valid),
        .job_base      (job_base),
        .job_credit    (job_credit),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .sample_credit (sample_credit),
        .line_valid    (line_valid),
        .line_data     (line_data),
        .out_credit    (out_credit)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Mismatch %s: expected %h, got %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // top digit of each word tells a job from a sample
    task automatic load_stimulus();
        for (int i = 0; i < STIM_WORDS; i++)
            stim_mem[i] = '0;
        $readmemh("testbench/nabp_stimulus.txt", stim_mem);
        for (int i = 0; i < STIM_WORDS; i++)
        begin
            case (stim_mem[i][19:16])
                4'h0: ;
                4'h1: job_q.push_back(stim_mem[i][ACCU_W-1:0]);
                4'h2: sample_q.push_back(stim_mem[i][DATA_W-1:0]);
                default:
                begin
                    $display("Error: unknown record kind in stimulus word %0d", i);
                    other_errors++;
                end
            endcase
        end
    endtask

    // reference model of fill, accumulate and shift per angle
    function automatic void build_expected();
        logic [DATA_W-1:0] taps [FILL_DEPTH];
        logic [ACCU_W-1:0] accu;
        logic [ACCU_W-1:0] accu_new;
        int                pos;
        bit                short_stream;
        pos = 0;
        short_stream = 1'b0;
        for (int j = 0; j < job_q.size(); j++)
        begin
            for (int k = 0; k < FILL_DEPTH; k++)
            begin
                if (pos < sample_q.size())
                    taps[k] = sample_q[pos];
                else
                    short_stream = 1'b1;
                pos++;
            end
            accu = '0;
            for (int s = 0; s < IMAGE_SIZE; s++)
            begin
                accu_new = accu + job_q[j];
                if (accu_new[ACCU_W-1:ACCU_FRAC] != accu[ACCU_W-1:ACCU_FRAC])
                begin
                    for (int k = 0; k < FILL_DEPTH - 1; k++)
                        taps[k] = taps[k + 1];
                    if (pos < sample_q.size())
                        taps[FILL_DEPTH - 1] = sample_q[pos];
                    else
                        short_stream = 1'b1;
                    pos++;
                end
                exp_q.push_back(taps[0]);
                accu = accu_new;
            end
        end
        if (short_stream)
        begin
            $display("Error: the stimulus file holds too few samples for its jobs");
            other_errors++;
        end
        samples_needed = pos;
        exp_total = exp_q.size();
    endfunction

    task automatic drive_jobs();
        int wait_cycles;
        for (int j = 0; j < job_q.size() && !stop_run; j++)
        begin
            wait_cycles = 0;
            @(posedge clk);
            while (jobs_sent - jobs_returned >= JOB_CREDITS && wait_cycles < WAIT_LIMIT)
            begin
                @(posedge clk);
                wait_cycles++;
            end
            if (wait_cycles >= WAIT_LIMIT)
            begin
                $display("Error: job source got no credit back within %0d cycles", WAIT_LIMIT);
                other_errors++;
                stop_run = 1'b1;
            end
            else
            begin
                job_valid <= 1'b1;
                job_base  <= job_q[j];
                jobs_sent++;
                @(posedge clk);
                job_valid <= 1'b0;
            end
        end
    endtask

    // random gaps between sends within the credits held
    task automatic drive_samples();
        int idx;
        int gap;
        int wait_cycles;
        idx = 0;
        gap = 0;
        wait_cycles = 0;
        while (idx < samples_needed && !stop_run)
        begin
            @(posedge clk);
            sample_valid <= 1'b0;
            if (gap == 0 && samples_sent - samples_returned < IN_DEPTH)
            begin
                sample_valid <= 1'b1;
                sample_data  <= sample_q[idx];
                idx++;
                samples_sent++;
                wait_cycles = 0;
                gap = $urandom_range(0, 3);
            end
            else
            begin
                if (gap > 0)
                    gap--;
                wait_cycles++;
                if (wait_cycles >= WAIT_LIMIT)
                begin
                    $display("Error: sample source got no credit back within %0d cycles",
                             WAIT_LIMIT);
                    other_errors++;
                    stop_run = 1'b1;
                end
            end
        end
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    // sink hands slots back with an occasional long hold
    task automatic return_credits();
        int gap;
        gap = 0;
        while (!stop_run)
        begin
            @(posedge clk);
            out_credit <= 1'b0;
            if (gap > 0)
                gap--;
            else if (lines_seen > credits_returned)
            begin
                out_credit <= 1'b1;
                credits_returned++;
                if ($urandom % 5 == 0)
                    gap = $urandom_range(8, 20);
                else
                    gap = $urandom_range(0, 2);
            end
        end
        out_credit <= 1'b0;
    endtask

    task automatic watch_outputs();
        while (!stop_run)
        begin
            @(negedge clk);
            if (line_valid)
            begin
                lines_seen++;
                lines_in_angle++;
                if (exp_q.size() == 0)
                begin
                    $display("Error: line_valid after the last expected output");
                    other_errors++;
                end
                else
                begin
                    exp_val = exp_q.pop_front();
                    check_value("line_data", 32'(exp_val), 32'(line_data));
                end
                if (lines_seen - credits_returned > OUT_CREDITS)
                begin
                    $display("Error: more outputs outstanding than the sink offered");
                    other_errors++;
                end
            end
            if (sample_credit)
                samples_returned++;
            if (job_credit)
            begin
                jobs_returned++;
                check_value("line_valid per angle", 32'(IMAGE_SIZE), 32'(lines_in_angle));
                lines_in_angle = 0;
            end
        end
    endtask

    initial
    begin
        int wait_cycles;
        void'($urandom(32'hcfc3a767));
        reset_n      = 1'b0;
        job_valid    = 1'b0;
        job_base     = '0;
        sample_valid = 1'b0;
        sample_data  = '0;
        out_credit   = 1'b0;
        load_stimulus();
        build_expected();

        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("job_credit", 32'h0, 32'(job_credit));
        check_value("sample_credit", 32'h0, 32'(sample_credit));
        check_value("line_valid", 32'h0, 32'(line_valid));

        fork
            watch_outputs();
            drive_jobs();
            drive_samples();
            return_credits();
        join_none

        // all angles credited back and every output seen
        wait_cycles = 0;
        while (!(jobs_returned == job_q.size() && lines_seen == exp_total) && !stop_run &&
               wait_cycles < RUN_LIMIT)
        begin
            @(posedge clk);
            wait_cycles++;
        end
        if (wait_cycles >= RUN_LIMIT)
        begin
            $display("Error: the angles did not finish within %0d cycles", RUN_LIMIT);
            other_errors++;
        end
        stop_run = 1'b1;

        check_value("job_credit pulses", 32'(job_q.size()), 32'(jobs_returned));
        check_value("sample_credit pulses", 32'(samples_needed), 32'(samples_returned));
        check_value("line_valid pulses", 32'(exp_total), 32'(lines_seen));

        $display("%0d mismatches, %0d other errors", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* verilog/nabp_top.sv */
`timescale 1ns/1ps

module nabp_top
#(
    parameter int DATA_WIDTH  = nabp_pkg::DEF_DATA_WIDTH,
    parameter int ACCU_WIDTH  = nabp_pkg::DEF_ACCU_WIDTH,
    parameter int ACCU_FRAC   = nabp_pkg::DEF_ACCU_FRAC,
    parameter int FILL_DEPTH  = nabp_pkg::DEF_FILL_DEPTH,
    parameter int IMAGE_SIZE  = nabp_pkg::DEF_IMAGE_SIZE,
    parameter int IN_DEPTH    = nabp_pkg::DEF_IN_DEPTH,
    parameter int OUT_CREDITS = nabp_pkg::DEF_OUT_CREDITS,
    parameter int JOB_CREDITS = nabp_pkg::DEF_JOB_CREDITS
)
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  job_valid,
    input  logic [ACCU_WIDTH-1:0] job_base,
    output logic                  job_credit,
    input  logic                  sample_valid,
    input  logic [DATA_WIDTH-1:0] sample_data,
    output logic                  sample_credit,
    output logic                  line_valid,
    output logic [DATA_WIDTH-1:0] line_data,
    input  logic                  out_credit
);

    logic                  fill_kick;
    logic                  shift_kick;
    logic [ACCU_WIDTH-1:0] accu_base;
    logic                  fill_done;
    logic                  shift_done;
    logic                  shift_req;
    logic                  shift_en;
    logic                  emit;
    logic                  step_ack;

    // state control
    nabp_sequencer #(
        .ACCU_WIDTH  (ACCU_WIDTH),
        .JOB_CREDITS (JOB_CREDITS)
    ) u_sequencer (
        .clk        (clk),
        .reset_n    (reset_n),
        .job_valid  (job_valid),
        .job_base   (job_base),
        .job_credit (job_credit),
        .fill_done  (fill_done),
        .shift_done (shift_done),
        .fill_kick  (fill_kick),
        .shift_kick (shift_kick),
        .accu_base  (accu_base)
    );

    nabp_shifter #(
        .ACCU_WIDTH (ACCU_WIDTH),
        .ACCU_FRAC  (ACCU_FRAC),
        .FILL_DEPTH (FILL_DEPTH),
        .IMAGE_SIZE (IMAGE_SIZE)
    ) u_shifter (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_kick  (fill_kick),
        .shift_kick (shift_kick),
        .accu_base  (accu_base),
        .step_ack   (step_ack),
        .fill_done  (fill_done),
        .shift_done (shift_done),
        .shift_req  (shift_req),
        .shift_en   (shift_en),
        .emit       (emit)
    );

    // sample FIFO, taps and output port
    nabp_filter_mapper #(
        .DATA_WIDTH  (DATA_WIDTH),
        .FILL_DEPTH  (FILL_DEPTH),
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_filter_mapper (
        .clk           (clk),
        .reset_n       (reset_n),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .sample_credit (sample_credit),
        .shift_req     (shift_req),
        .shift_en      (shift_en),
        .emit          (emit),
        .step_ack      (step_ack),
        .line_valid    (line_valid),
        .line_data     (line_data),
        .out_credit    (out_credit)
    );

endmodule

/* verilog/nabp_filter_mapper.sv */
`timescale 1ns/1ps

module nabp_filter_mapper
#(
    parameter int DATA_WIDTH  = nabp_pkg::DEF_DATA_WIDTH,
    parameter int FILL_DEPTH  = nabp_pkg::DEF_FILL_DEPTH,
    parameter int IN_DEPTH    = nabp_pkg::DEF_IN_DEPTH,
    parameter int OUT_CREDITS = nabp_pkg::DEF_OUT_CREDITS
)
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  sample_valid,
    input  logic [DATA_WIDTH-1:0] sample_data,
    output logic                  sample_credit,
    input  logic                  shift_req,
    input  logic                  shift_en,
    input  logic                  emit,
    output logic                  step_ack,
    output logic                  line_valid,
    output logic [DATA_WIDTH-1:0] line_data,
    input  logic                  out_credit
);

    localparam int PTR_W   = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W   = $clog2(IN_DEPTH + 1);
    localparam int OCRED_W = $clog2(OUT_CREDITS + 1);

    logic [DATA_WIDTH-1:0] fifo_mem [IN_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      fifo_count;
    logic                  pop;
    logic                  emit_fire;

    logic [DATA_WIDTH-1:0] taps      [FILL_DEPTH];
    logic [DATA_WIDTH-1:0] taps_next [FILL_DEPTH];
    logic [OCRED_W-1:0]    out_cnt;

    // ack once the sample and the output slot the step needs are both there
    assign step_ack  = shift_req && (!shift_en || fifo_count != '0) &&
                       (!emit || out_cnt != '0);
    assign pop       = step_ack && shift_en;
    assign emit_fire = step_ack && emit;

    // input FIFO, push has no back-pressure, credits bound it
    always_ff @(posedge clk)
    begin
        if (sample_valid)
            fifo_mem[wr_ptr] <= sample_data;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fifo_count    <= '0;
            sample_credit <= 1'b0;
        end
        else
        begin
            if (sample_valid)
                wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (sample_valid && !pop)
                fifo_count <= fifo_count + 1'b1;
            else if (pop && !sample_valid)
                fifo_count <= fifo_count - 1'b1;
            // one credit back per consumed sample
            sample_credit <= pop;
        end
    end

    // taps[0] is the oldest entry
    always_comb
    begin
        taps_next = taps;
        if (shift_en)
        begin
            for (int i = 0; i < FILL_DEPTH - 1; i++)
                taps_next[i] = taps[i + 1];
            taps_next[FILL_DEPTH - 1] = fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk)
    begin
        if (step_ack)
            taps <= taps_next;
        if (emit_fire)
            line_data <= taps_next[0];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            line_valid <= 1'b0;
        else
            line_valid <= emit_fire;
    end

    // output credits, a return and an emit in one cycle cancel out
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            out_cnt <= OCRED_W'(OUT_CREDITS);
        else if (emit_fire && !out_credit)
            out_cnt <= out_cnt - 1'b1;
        else if (out_credit && !emit_fire)
            out_cnt <= out_cnt + 1'b1;
    end

    fifo_overflow_check: assert property (
        @(posedge clk) disable iff (!reset_n)
        sample_valid |-> (fifo_count != CNT_W'(IN_DEPTH))
    )
    else
        $error("sample pushed into a full input FIFO");

    out_credit_check: assert property (
        @(posedge clk) disable iff (!reset_n)
        out_cnt <= OCRED_W'(OUT_CREDITS)
    )
    else
        $error("sink returned more output credits than it was given");

endmodule

/* verilog/nabp_shifter.sv */
`timescale 1ns/1ps

module nabp_shifter
#(
    parameter int ACCU_WIDTH = nabp_pkg::DEF_ACCU_WIDTH,
    parameter int ACCU_FRAC  = nabp_pkg::DEF_ACCU_FRAC,
    parameter int FILL_DEPTH = nabp_pkg::DEF_FILL_DEPTH,
    parameter int IMAGE_SIZE = nabp_pkg::DEF_IMAGE_SIZE
)
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  fill_kick,
    input  logic                  shift_kick,
    input  logic [ACCU_WIDTH-1:0] accu_base,
    input  logic                  step_ack,
    output logic                  fill_done,
    output logic                  shift_done,
    output logic                  shift_req,
    output logic                  shift_en,
    output logic                  emit
);

    localparam int FILL_CW  = $clog2(FILL_DEPTH + 1);
    localparam int SHIFT_CW = $clog2(IMAGE_SIZE + 1);

    nabp_pkg::shifter_state_e state;
    logic [FILL_CW-1:0]       fill_cnt;
    logic [SHIFT_CW-1:0]      shift_cnt;
    logic [ACCU_WIDTH-1:0]    accu;
    logic [ACCU_WIDTH-1:0]    accu_next;
    logic                     in_fill;
    logic                     in_shift;

    assign in_fill  = (state == nabp_pkg::sh_fill);
    assign in_shift = (state == nabp_pkg::sh_shift);

    // wraps freely, only integer boundary crossings matter
    assign accu_next = accu + accu_base;

    assign shift_req = in_fill || in_shift;
    assign emit      = in_shift;

    // fill always shifts in, shift phase only on a new integer part
    always_comb
    begin
        shift_en = 1'b0;
        if (in_fill)
            shift_en = 1'b1;
        else if (in_shift)
            shift_en = (accu_next[ACCU_WIDTH-1:ACCU_FRAC] != accu[ACCU_WIDTH-1:ACCU_FRAC]);
    end

    // done pulses fire with the last acked step
    assign fill_done  = in_fill && step_ack && (fill_cnt == FILL_CW'(1));
    assign shift_done = in_shift && step_ack && (shift_cnt == SHIFT_CW'(1));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= nabp_pkg::sh_ready;
        else
        begin
            case (state)
                nabp_pkg::sh_ready:
                    if (fill_kick)
                        state <= nabp_pkg::sh_fill;
                nabp_pkg::sh_fill:
                    if (fill_done)
                        state <= nabp_pkg::sh_fill_done;
                nabp_pkg::sh_fill_done:
                    if (shift_kick)
                        state <= nabp_pkg::sh_shift;
                nabp_pkg::sh_shift:
                    if (shift_done)
                        state <= nabp_pkg::sh_ready;
                default:
                    state <= nabp_pkg::sh_ready;
            endcase
        end
    end

    // step counters and accumulator, loaded by the kicks
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_cnt  <= '0;
            shift_cnt <= '0;
            accu      <= '0;
        end
        else
        begin
            if (fill_kick && state == nabp_pkg::sh_ready)
                fill_cnt <= FILL_CW'(FILL_DEPTH);
            else if (in_fill && step_ack)
                fill_cnt <= fill_cnt - 1'b1;

            if (shift_kick && state == nabp_pkg::sh_fill_done)
            begin
                shift_cnt <= SHIFT_CW'(IMAGE_SIZE);
                accu      <= '0;
            end
            else if (in_shift && step_ack)
            begin
                shift_cnt <= shift_cnt - 1'b1;
                accu      <= accu_next;
            end
        end
    end

    kick_order_check: assert property (
        @(posedge clk) disable iff (!reset_n)
        shift_kick |-> (state == nabp_pkg::sh_fill_done)
    )
    else
        $error("shift_kick outside the fill done state");

    ack_check: assert property (
        @(posedge clk) disable iff (!reset_n)
        step_ack |-> shift_req
    )
    else
        $error("step_ack without a pending shift_req");

endmodule

/* verilog/nabp_sequencer.sv */
`timescale 1ns/1ps

module nabp_sequencer
#(
    parameter int ACCU_WIDTH  = nabp_pkg::DEF_ACCU_WIDTH,
    parameter int JOB_CREDITS = nabp_pkg::DEF_JOB_CREDITS
)
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  job_valid,
    input  logic [ACCU_WIDTH-1:0] job_base,
    output logic                  job_credit,
    input  logic                  fill_done,
    input  logic                  shift_done,
    output logic                  fill_kick,
    output logic                  shift_kick,
    output logic [ACCU_WIDTH-1:0] accu_base
);

    localparam int CREDIT_W = $clog2(JOB_CREDITS + 1);

    nabp_pkg::seq_state_e state;
    logic                 job_accept;
    logic [CREDIT_W-1:0]  src_credits;

    assign job_accept = (state == nabp_pkg::seq_idle) && job_valid;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state      <= nabp_pkg::seq_idle;
            fill_kick  <= 1'b0;
            shift_kick <= 1'b0;
            job_credit <= 1'b0;
        end
        else
        begin
            // kicks and credit are single-cycle pulses
            fill_kick  <= 1'b0;
            shift_kick <= 1'b0;
            job_credit <= 1'b0;
            case (state)
                nabp_pkg::seq_idle:
                    if (job_valid)
                    begin
                        fill_kick <= 1'b1;
                        state     <= nabp_pkg::seq_filling;
                    end
                nabp_pkg::seq_filling:
                    if (fill_done)
                    begin
                        shift_kick <= 1'b1;
                        state      <= nabp_pkg::seq_shifting;
                    end
                nabp_pkg::seq_shifting:
                    if (shift_done)
                    begin
                        // angle finished, hand the slot back
                        job_credit <= 1'b1;
                        state      <= nabp_pkg::seq_idle;
                    end
                default:
                    state <= nabp_pkg::seq_idle;
            endcase
        end
    end

    // step size stays stable for the whole angle
    always_ff @(posedge clk)
    begin
        if (job_accept)
            accu_base <= job_base;
    end

    // mirror of the credits the job source still holds
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            src_credits <= CREDIT_W'(JOB_CREDITS);
        else if (job_valid && !job_credit)
            src_credits <= src_credits - 1'b1;
        else if (job_credit && !job_valid)
            src_credits <= src_credits + 1'b1;
    end

    // a job while busy means the source ignored its credits
    job_credit_check: assert property (
        @(posedge clk) disable iff (!reset_n)
        job_valid |-> (state == nabp_pkg::seq_idle) && (src_credits != '0)
    )
    else
        $error("job_valid while sequencer busy or source out of credits");

endmodule

/* verilog/nabp_pkg.sv */
package nabp_pkg;

    // sample and accumulator geometry
    localparam int DEF_DATA_WIDTH = 16;
    localparam int DEF_ACCU_WIDTH = 16;

    // fraction bits of the accumulator, the rest is the integer part
    localparam int DEF_ACCU_FRAC = 12;

    // tap shift register length, one partition only
    localparam int DEF_FILL_DEPTH = 4;

    // steps across one image row per angle
    localparam int DEF_IMAGE_SIZE = 8;

    // input FIFO entries, same as the sample credits of the source
    localparam int DEF_IN_DEPTH = 4;

    // slots the output sink offers after reset
    localparam int DEF_OUT_CREDITS = 2;

    // angle jobs the source may have in flight
    localparam int DEF_JOB_CREDITS = 1;

    // shifter phase
    typedef enum logic [1:0]
    {
        sh_ready     = 2'd0,
        sh_fill      = 2'd1,
        sh_fill_done = 2'd2,
        sh_shift     = 2'd3
    } shifter_state_e;

    // sequencer state, one angle job at a time
    typedef enum logic [1:0]
    {
        seq_idle     = 2'd0,
        seq_filling  = 2'd1,
        seq_shifting = 2'd2
    } seq_state_e;

endpackage
